// ==== verilog/vdma_cfg.svh ====
`ifndef VDMA_CFG_SVH
`define VDMA_CFG_SVH

// bus widths
`define VDMA_ADDR_W         32
`define VDMA_DATA_W         32
`define VDMA_ID_W           6
`define VDMA_PIX_W          24
`define VDMA_WB_ADR_W       8
`define VDMA_WB_DAT_W       32

// field widths
`define VDMA_H_W            12
`define VDMA_V_W            12
`define VDMA_STRIDE_W       14
`define VDMA_LEN_W          8
`define VDMA_INDEX_W        8

// low address bits cleared for 32-bit beats
`define VDMA_ADDR_LSB       2

// register reset values
`define VDMA_INIT_WIDTH     640
`define VDMA_INIT_HEIGHT    480
`define VDMA_INIT_STRIDE    4096
`define VDMA_INIT_ARLEN     255
`define VDMA_CORE_ID        32'h5644_4d41
`define VDMA_CORE_VERSION   32'h0001_0000

`endif

// ==== verilog/vdma_pkg.sv ====
`include "vdma_cfg.svh"

package vdma_pkg;

	typedef logic [`VDMA_ADDR_W-1:0]   addr_t;
	typedef logic [`VDMA_H_W-1:0]      hcnt_t;
	typedef logic [`VDMA_V_W-1:0]      vcnt_t;
	typedef logic [`VDMA_STRIDE_W-1:0] stride_t;
	typedef logic [`VDMA_LEN_W-1:0]    len_t;
	typedef logic [`VDMA_INDEX_W-1:0]  index_t;

	// wishbone word offsets (byte offset >> 2)
	typedef enum logic [`VDMA_WB_ADR_W-1:0] {
		REG_ID             = 'h00,
		REG_VERSION        = 'h01,
		REG_CTL_CONTROL    = 'h04,
		REG_CTL_STATUS     = 'h05,
		REG_CTL_INDEX      = 'h07,
		REG_PARAM_ADDR     = 'h08,
		REG_PARAM_STRIDE   = 'h09,
		REG_PARAM_WIDTH    = 'h0a,
		REG_PARAM_HEIGHT   = 'h0b,
		REG_PARAM_ARLEN    = 'h0f,
		REG_MONITOR_ADDR   = 'h10,
		REG_MONITOR_STRIDE = 'h11,
		REG_MONITOR_WIDTH  = 'h12,
		REG_MONITOR_HEIGHT = 'h13,
		REG_MONITOR_ARLEN  = 'h17
	} reg_ofs_e;

endpackage

// ==== verilog/vdma_regs.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module vdma_regs (
	input  logic                         s_wb_clk_i,
	input  logic                         s_wb_rst_i,
	input  logic [`VDMA_WB_ADR_W-1:0]    s_wb_adr_i,
	input  logic [`VDMA_WB_DAT_W-1:0]    s_wb_dat_i,
	input  logic                         s_wb_we_i,
	input  logic [`VDMA_WB_DAT_W/8-1:0]  s_wb_sel_i,
	input  logic                         s_wb_stb_i,
	output logic [`VDMA_WB_DAT_W-1:0]    s_wb_dat_o,
	output logic                         s_wb_ack_o,
	input  logic                         busy_i,
	input  vdma_pkg::index_t             index_i,
	input  vdma_pkg::addr_t              mon_addr_i,
	input  vdma_pkg::stride_t            mon_stride_i,
	input  vdma_pkg::hcnt_t              mon_width_i,
	input  vdma_pkg::vcnt_t              mon_height_i,
	input  vdma_pkg::len_t               mon_arlen_i,
	output logic                         ctl_enable_o,
	output logic                         ctl_update_o,
	output vdma_pkg::addr_t              param_addr_o,
	output vdma_pkg::stride_t            param_stride_o,
	output vdma_pkg::hcnt_t              param_width_o,
	output vdma_pkg::vcnt_t              param_height_o,
	output vdma_pkg::len_t               param_arlen_o
);

	logic [1:0]                ctl_control;
	logic                      prev_index;
	logic                      wr_en;
	logic [`VDMA_WB_DAT_W-1:0] wr_word;
	vdma_pkg::addr_t           addr_aligned;
	vdma_pkg::stride_t         stride_aligned;

	// byte lanes not selected keep the current register contents
	function automatic logic [`VDMA_WB_DAT_W-1:0] wb_merge(
		input logic [`VDMA_WB_DAT_W-1:0]   cur,
		input logic [`VDMA_WB_DAT_W-1:0]   dat,
		input logic [`VDMA_WB_DAT_W/8-1:0] sel
	);
		logic [`VDMA_WB_DAT_W-1:0] res;
		res = cur;
		for (int i = 0; i < `VDMA_WB_DAT_W/8; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = dat[8*i +: 8];
			end
		end
		return res;
	endfunction

	assign s_wb_ack_o     = s_wb_stb_i;
	assign wr_en          = s_wb_stb_i && s_wb_we_i;
	assign wr_word        = wb_merge(s_wb_dat_o, s_wb_dat_i, s_wb_sel_i);
	assign addr_aligned   = {wr_word[`VDMA_ADDR_W-1:`VDMA_ADDR_LSB], {`VDMA_ADDR_LSB{1'b0}}};
	assign stride_aligned = {wr_word[`VDMA_STRIDE_W-1:`VDMA_ADDR_LSB], {`VDMA_ADDR_LSB{1'b0}}};

	assign ctl_enable_o = ctl_control[0];
	assign ctl_update_o = ctl_control[1];

	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			ctl_control    <= 2'b00;
			prev_index     <= 1'b0;
			param_addr_o   <= '0;
			param_stride_o <= `VDMA_INIT_STRIDE;
			param_width_o  <= `VDMA_INIT_WIDTH;
			param_height_o <= `VDMA_INIT_HEIGHT;
			param_arlen_o  <= `VDMA_INIT_ARLEN;
		end else begin
			if (wr_en) begin
				case (s_wb_adr_i)
				vdma_pkg::REG_CTL_CONTROL:  ctl_control    <= wr_word[1:0];
				vdma_pkg::REG_PARAM_ADDR:   param_addr_o   <= addr_aligned;
				vdma_pkg::REG_PARAM_STRIDE: param_stride_o <= stride_aligned;
				vdma_pkg::REG_PARAM_WIDTH:  param_width_o  <= wr_word[`VDMA_H_W-1:0];
				vdma_pkg::REG_PARAM_HEIGHT: param_height_o <= wr_word[`VDMA_V_W-1:0];
				vdma_pkg::REG_PARAM_ARLEN:  param_arlen_o  <= wr_word[`VDMA_LEN_W-1:0];
				default: ;
				endcase
			end

			// update bit drops once a new frame has taken the parameters
			prev_index <= index_i[0];
			if (prev_index != index_i[0]) begin
				ctl_control[1] <= 1'b0;
			end
		end
	end

	always_comb begin
		case (s_wb_adr_i)
		vdma_pkg::REG_ID:             s_wb_dat_o = `VDMA_CORE_ID;
		vdma_pkg::REG_VERSION:        s_wb_dat_o = `VDMA_CORE_VERSION;
		vdma_pkg::REG_CTL_CONTROL:    s_wb_dat_o = `VDMA_WB_DAT_W'(ctl_control);
		vdma_pkg::REG_CTL_STATUS:     s_wb_dat_o = `VDMA_WB_DAT_W'(busy_i);
		vdma_pkg::REG_CTL_INDEX:      s_wb_dat_o = `VDMA_WB_DAT_W'(index_i);
		vdma_pkg::REG_PARAM_ADDR:     s_wb_dat_o = `VDMA_WB_DAT_W'(param_addr_o);
		vdma_pkg::REG_PARAM_STRIDE:   s_wb_dat_o = `VDMA_WB_DAT_W'(param_stride_o);
		vdma_pkg::REG_PARAM_WIDTH:    s_wb_dat_o = `VDMA_WB_DAT_W'(param_width_o);
		vdma_pkg::REG_PARAM_HEIGHT:   s_wb_dat_o = `VDMA_WB_DAT_W'(param_height_o);
		vdma_pkg::REG_PARAM_ARLEN:    s_wb_dat_o = `VDMA_WB_DAT_W'(param_arlen_o);
		vdma_pkg::REG_MONITOR_ADDR:   s_wb_dat_o = `VDMA_WB_DAT_W'(mon_addr_i);
		vdma_pkg::REG_MONITOR_STRIDE: s_wb_dat_o = `VDMA_WB_DAT_W'(mon_stride_i);
		vdma_pkg::REG_MONITOR_WIDTH:  s_wb_dat_o = `VDMA_WB_DAT_W'(mon_width_i);
		vdma_pkg::REG_MONITOR_HEIGHT: s_wb_dat_o = `VDMA_WB_DAT_W'(mon_height_i);
		vdma_pkg::REG_MONITOR_ARLEN:  s_wb_dat_o = `VDMA_WB_DAT_W'(mon_arlen_i);
		default:                      s_wb_dat_o = '0;
		endcase
	end

endmodule

// ==== verilog/vdma_ar_gen.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module vdma_ar_gen (
	input  logic                s_wb_clk_i,
	input  logic                s_wb_rst_i,
	input  logic                ctl_enable_i,
	input  logic                ctl_update_i,
	input  vdma_pkg::addr_t     param_addr_i,
	input  vdma_pkg::stride_t   param_stride_i,
	input  vdma_pkg::hcnt_t     param_width_i,
	input  vdma_pkg::vcnt_t     param_height_i,
	input  vdma_pkg::len_t      param_arlen_i,
	input  logic                frame_done_i,
	input  logic                m_axi4_arready_i,
	output vdma_pkg::addr_t     m_axi4_araddr_o,
	output vdma_pkg::len_t      m_axi4_arlen_o,
	output logic                m_axi4_arvalid_o,
	output logic                busy_o,
	output vdma_pkg::index_t    index_o,
	output logic                frame_start_o,
	output vdma_pkg::addr_t     mon_addr_o,
	output vdma_pkg::stride_t   mon_stride_o,
	output vdma_pkg::hcnt_t     mon_width_o,
	output vdma_pkg::vcnt_t     mon_height_o,
	output vdma_pkg::len_t      mon_arlen_o
);

	typedef enum logic [1:0] {ST_IDLE, ST_START, ST_ADDR, ST_WAIT} state_e;

	state_e            state;
	vdma_pkg::addr_t   line_base;
	vdma_pkg::addr_t   next_base;
	vdma_pkg::hcnt_t   x_req;
	vdma_pkg::vcnt_t   y_cnt;
	vdma_pkg::len_t    first_len;
	vdma_pkg::len_t    next_len;
	logic              ar_hs;
	logic              line_end;
	logic              last_line;

	// burst length minus one for the beats still left in the line
	function automatic vdma_pkg::len_t burst_len(
		input vdma_pkg::len_t  max_len,
		input vdma_pkg::hcnt_t rest
	);
		if (rest > vdma_pkg::hcnt_t'(max_len)) begin
			return max_len;
		end
		return vdma_pkg::len_t'(rest - 1'b1);
	endfunction

	assign ar_hs     = m_axi4_arvalid_o && m_axi4_arready_i;
	assign line_end  = (x_req == mon_width_o);
	assign last_line = (y_cnt == vdma_pkg::vcnt_t'(mon_height_o - 1'b1));
	assign next_base = line_base + vdma_pkg::addr_t'(mon_stride_o);
	assign next_len  = burst_len(mon_arlen_o, line_end ? mon_width_o : mon_width_o - x_req);
	assign first_len = burst_len(ctl_update_i ? param_arlen_i : mon_arlen_o,
	                             ctl_update_i ? param_width_i : mon_width_o);

	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			state            <= ST_IDLE;
			m_axi4_arvalid_o <= 1'b0;
			busy_o           <= 1'b0;
			index_o          <= '0;
			frame_start_o    <= 1'b0;
			mon_addr_o       <= '0;
			mon_stride_o     <= `VDMA_INIT_STRIDE;
			mon_width_o      <= `VDMA_INIT_WIDTH;
			mon_height_o     <= `VDMA_INIT_HEIGHT;
			mon_arlen_o      <= `VDMA_INIT_ARLEN;
		end else begin
			frame_start_o <= 1'b0;
			case (state)
			ST_IDLE: begin
				if (ctl_enable_i) begin
					frame_start_o <= 1'b1;
					state         <= ST_START;
				end
			end
			ST_START: begin
				if (ctl_update_i) begin
					mon_addr_o   <= param_addr_i;
					mon_stride_o <= param_stride_i;
					mon_width_o  <= param_width_i;
					mon_height_o <= param_height_i;
					mon_arlen_o  <= param_arlen_i;
				end
				line_base        <= ctl_update_i ? param_addr_i : mon_addr_o;
				m_axi4_araddr_o  <= ctl_update_i ? param_addr_i : mon_addr_o;
				m_axi4_arlen_o   <= first_len;
				x_req            <= vdma_pkg::hcnt_t'(first_len) + 1'b1;
				y_cnt            <= '0;
				m_axi4_arvalid_o <= 1'b1;
				index_o          <= index_o + 1'b1;
				busy_o           <= 1'b1;
				state            <= ST_ADDR;
			end
			ST_ADDR: begin
				if (ar_hs) begin
					if (line_end && last_line) begin
						m_axi4_arvalid_o <= 1'b0;
						state            <= ST_WAIT;
					end else if (line_end) begin
						y_cnt           <= y_cnt + 1'b1;
						line_base       <= next_base;
						m_axi4_araddr_o <= next_base;
						m_axi4_arlen_o  <= next_len;
						x_req           <= vdma_pkg::hcnt_t'(next_len) + 1'b1;
					end else begin
						m_axi4_araddr_o <= line_base
						                   + (vdma_pkg::addr_t'(x_req) << `VDMA_ADDR_LSB);
						m_axi4_arlen_o  <= next_len;
						x_req           <= x_req + vdma_pkg::hcnt_t'(next_len) + 1'b1;
					end
				end
			end
			// requests done, data may still be in flight
			ST_WAIT: begin
				if (frame_done_i) begin
					busy_o <= 1'b0;
					state  <= ST_IDLE;
				end
			end
			default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== verilog/vdma_beat_tracker.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module vdma_beat_tracker (
	input  logic              s_wb_clk_i,
	input  logic              s_wb_rst_i,
	input  logic              frame_start_i,
	input  logic              beat_i,
	input  vdma_pkg::hcnt_t   width_i,
	input  vdma_pkg::vcnt_t   height_i,
	output logic              sof_o,
	output logic              eol_o,
	output logic              frame_done_o
);

	vdma_pkg::hcnt_t x_cnt;
	vdma_pkg::vcnt_t y_cnt;
	logic            last_line;

	// position of the beat currently on the R channel
	assign sof_o     = (x_cnt == '0) && (y_cnt == '0);
	assign eol_o     = (x_cnt == vdma_pkg::hcnt_t'(width_i - 1'b1));
	assign last_line = (y_cnt == vdma_pkg::vcnt_t'(height_i - 1'b1));

	assign frame_done_o = beat_i && eol_o && last_line;

	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (frame_start_i) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (beat_i) begin
			if (eol_o) begin
				x_cnt <= '0;
				y_cnt <= y_cnt + 1'b1;
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/vdma_stream_out.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module vdma_stream_out (
	input  logic                    s_wb_clk_i,
	input  logic                    s_wb_rst_i,
	input  logic [`VDMA_DATA_W-1:0] rdata_i,
	input  logic                    rvalid_i,
	input  logic                    sof_i,
	input  logic                    eol_i,
	input  logic                    m_axi4s_tready_i,
	output logic                    rready_o,
	output logic [`VDMA_PIX_W-1:0]  m_axi4s_tdata_o,
	output logic                    m_axi4s_tuser_o,
	output logic                    m_axi4s_tlast_o,
	output logic                    m_axi4s_tvalid_o
);

	logic load;

	// accept a beat when the slot is free or drains this cycle
	assign rready_o = !m_axi4s_tvalid_o || m_axi4s_tready_i;
	assign load     = rvalid_i && rready_o;

	always_ff @(posedge s_wb_clk_i) begin
		if (s_wb_rst_i) begin
			m_axi4s_tvalid_o <= 1'b0;
		end else if (load) begin
			m_axi4s_tvalid_o <= 1'b1;
		end else if (m_axi4s_tready_i) begin
			m_axi4s_tvalid_o <= 1'b0;
		end
	end

	// pixel and flags
	always_ff @(posedge s_wb_clk_i) begin
		if (load) begin
			m_axi4s_tdata_o <= rdata_i[`VDMA_PIX_W-1:0];
			m_axi4s_tuser_o <= sof_i;
			m_axi4s_tlast_o <= eol_i;
		end
	end

endmodule

// ==== verilog/vdma_top.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module vdma_top (
	input  logic                         s_wb_clk_i,
	input  logic                         s_wb_rst_i,
	input  logic [`VDMA_WB_ADR_W-1:0]    s_wb_adr_i,
	input  logic [`VDMA_WB_DAT_W-1:0]    s_wb_dat_i,
	input  logic                         s_wb_we_i,
	input  logic [`VDMA_WB_DAT_W/8-1:0]  s_wb_sel_i,
	input  logic                         s_wb_stb_i,
	output logic [`VDMA_WB_DAT_W-1:0]    s_wb_dat_o,
	output logic                         s_wb_ack_o,

	output logic [`VDMA_ID_W-1:0]        m_axi4_arid_o,
	output vdma_pkg::addr_t              m_axi4_araddr_o,
	output logic [1:0]                   m_axi4_arburst_o,
	output vdma_pkg::len_t               m_axi4_arlen_o,
	output logic [2:0]                   m_axi4_arsize_o,
	output logic                         m_axi4_arvalid_o,
	input  logic                         m_axi4_arready_i,
	input  logic [`VDMA_DATA_W-1:0]      m_axi4_rdata_i,
	input  logic                         m_axi4_rvalid_i,
	output logic                         m_axi4_rready_o,

	output logic [`VDMA_PIX_W-1:0]       m_axi4s_tdata_o,
	output logic                         m_axi4s_tuser_o,
	output logic                         m_axi4s_tlast_o,
	output logic                         m_axi4s_tvalid_o,
	input  logic                         m_axi4s_tready_i
);

	logic              ctl_enable;
	logic              ctl_update;
	logic              busy;
	logic              frame_start;
	logic              frame_done;
	logic              beat;
	logic              sof;
	logic              eol;
	vdma_pkg::index_t  index;
	vdma_pkg::addr_t   param_addr;
	vdma_pkg::stride_t param_stride;
	vdma_pkg::hcnt_t   param_width;
	vdma_pkg::vcnt_t   param_height;
	vdma_pkg::len_t    param_arlen;
	vdma_pkg::addr_t   mon_addr;
	vdma_pkg::stride_t mon_stride;
	vdma_pkg::hcnt_t   mon_width;
	vdma_pkg::vcnt_t   mon_height;
	vdma_pkg::len_t    mon_arlen;

	// ----------------------------------------
	// fixed AR attributes: INCR, 4 bytes, id 0
	// ----------------------------------------
	assign m_axi4_arid_o    = '0;
	assign m_axi4_arburst_o = 2'b01;
	assign m_axi4_arsize_o  = 3'd`VDMA_ADDR_LSB;

	assign beat = m_axi4_rvalid_i && m_axi4_rready_o;

	vdma_regs u_regs (
		.s_wb_clk_i     (s_wb_clk_i),
		.s_wb_rst_i     (s_wb_rst_i),
		.s_wb_adr_i     (s_wb_adr_i),
		.s_wb_dat_i     (s_wb_dat_i),
		.s_wb_we_i      (s_wb_we_i),
		.s_wb_sel_i     (s_wb_sel_i),
		.s_wb_stb_i     (s_wb_stb_i),
		.s_wb_dat_o     (s_wb_dat_o),
		.s_wb_ack_o     (s_wb_ack_o),
		.busy_i         (busy),
		.index_i        (index),
		.mon_addr_i     (mon_addr),
		.mon_stride_i   (mon_stride),
		.mon_width_i    (mon_width),
		.mon_height_i   (mon_height),
		.mon_arlen_i    (mon_arlen),
		.ctl_enable_o   (ctl_enable),
		.ctl_update_o   (ctl_update),
		.param_addr_o   (param_addr),
		.param_stride_o (param_stride),
		.param_width_o  (param_width),
		.param_height_o (param_height),
		.param_arlen_o  (param_arlen)
	);

	vdma_ar_gen u_ar_gen (
		.s_wb_clk_i       (s_wb_clk_i),
		.s_wb_rst_i       (s_wb_rst_i),
		.ctl_enable_i     (ctl_enable),
		.ctl_update_i     (ctl_update),
		.param_addr_i     (param_addr),
		.param_stride_i   (param_stride),
		.param_width_i    (param_width),
		.param_height_i   (param_height),
		.param_arlen_i    (param_arlen),
		.frame_done_i     (frame_done),
		.m_axi4_arready_i (m_axi4_arready_i),
		.m_axi4_araddr_o  (m_axi4_araddr_o),
		.m_axi4_arlen_o   (m_axi4_arlen_o),
		.m_axi4_arvalid_o (m_axi4_arvalid_o),
		.busy_o           (busy),
		.index_o          (index),
		.frame_start_o    (frame_start),
		.mon_addr_o       (mon_addr),
		.mon_stride_o     (mon_stride),
		.mon_width_o      (mon_width),
		.mon_height_o     (mon_height),
		.mon_arlen_o      (mon_arlen)
	);

	vdma_beat_tracker u_beat_tracker (
		.s_wb_clk_i    (s_wb_clk_i),
		.s_wb_rst_i    (s_wb_rst_i),
		.frame_start_i (frame_start),
		.beat_i        (beat),
		.width_i       (mon_width),
		.height_i      (mon_height),
		.sof_o         (sof),
		.eol_o         (eol),
		.frame_done_o  (frame_done)
	);

	vdma_stream_out u_stream_out (
		.s_wb_clk_i       (s_wb_clk_i),
		.s_wb_rst_i       (s_wb_rst_i),
		.rdata_i          (m_axi4_rdata_i),
		.rvalid_i         (m_axi4_rvalid_i),
		.sof_i            (sof),
		.eol_i            (eol),
		.m_axi4s_tready_i (m_axi4s_tready_i),
		.rready_o         (m_axi4_rready_o),
		.m_axi4s_tdata_o  (m_axi4s_tdata_o),
		.m_axi4s_tuser_o  (m_axi4s_tuser_o),
		.m_axi4s_tlast_o  (m_axi4s_tlast_o),
		.m_axi4s_tvalid_o (m_axi4s_tvalid_o)
	);

endmodule

// ==== dv/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o;
	end

	// reset held for two rising edges
	initial begin
		rst_o = 1'b1;
		repeat (2) @(posedge clk_o);
		#10 rst_o = 1'b0;
	end

endmodule

// ==== dv/tb_vdma_asserts.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module tb_vdma_asserts (
	input logic                    s_wb_clk_i,
	input logic                    s_wb_rst_i,
	input logic                    m_axi4_arvalid_o,
	input logic                    m_axi4_arready_i,
	input logic [`VDMA_ADDR_W-1:0] m_axi4_araddr_o,
	input logic [`VDMA_LEN_W-1:0]  m_axi4_arlen_o,
	input logic                    m_axi4s_tvalid_o,
	input logic                    m_axi4s_tready_i,
	input logic [`VDMA_PIX_W-1:0]  m_axi4s_tdata_o
);

	ar_hold: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
		m_axi4_arvalid_o && !m_axi4_arready_i |=> m_axi4_arvalid_o
		&& $stable(m_axi4_araddr_o) && $stable(m_axi4_arlen_o))
		else $error("arvalid dropped or AR changed before handshake");

	t_hold: assert property (@(posedge s_wb_clk_i) disable iff (s_wb_rst_i)
		m_axi4s_tvalid_o && !m_axi4s_tready_i |=> m_axi4s_tvalid_o
		&& $stable(m_axi4s_tdata_o))
		else $error("tvalid dropped or tdata changed before handshake");

	// first reset edge clears the register
	t_reset: assert property (@(posedge s_wb_clk_i)
		s_wb_rst_i && $past(s_wb_rst_i) |-> !m_axi4s_tvalid_o)
		else $error("tvalid high during reset");

endmodule

bind vdma_top tb_vdma_asserts u_asserts (
	.s_wb_clk_i       (s_wb_clk_i),
	.s_wb_rst_i       (s_wb_rst_i),
	.m_axi4_arvalid_o (m_axi4_arvalid_o),
	.m_axi4_arready_i (m_axi4_arready_i),
	.m_axi4_araddr_o  (m_axi4_araddr_o),
	.m_axi4_arlen_o   (m_axi4_arlen_o),
	.m_axi4s_tvalid_o (m_axi4s_tvalid_o),
	.m_axi4s_tready_i (m_axi4s_tready_i),
	.m_axi4s_tdata_o  (m_axi4s_tdata_o)
);

// ==== dv/tb_vdma.sv ====
`timescale 1ns/1ps
`include "vdma_cfg.svh"

module tb_vdma;

	logic        clk;
	logic        rst;
	logic [7:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic        wb_we;
	logic [3:0]  wb_sel;
	logic        wb_stb;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic [5:0]  arid;
	logic [31:0] araddr;
	logic [1:0]  arburst;
	logic [7:0]  arlen;
	logic [2:0]  arsize;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic        rvalid;
	logic        rready;
	logic [23:0] tdata;
	logic        tuser;
	logic        tlast;
	logic        tvalid;
	logic        tready;

	logic [31:0] lfsr_state = 32'd93191;
	int          checks;
	int          errors;
	int          tests;
	int          pix_cnt;
	int          ar_cnt;
	bit          ready_mode;
	int          exp_w;
	int          exp_h;
	int          exp_stride;
	int          exp_arlen;
	int          exp_bursts;
	logic [31:0] exp_addr;
	logic [31:0] ar_addr_q[$];
	int          ar_len_q[$];
	logic [31:0] cur_addr;
	int          beats_left;

	tb_clkgen u_clkgen (.clk_o(clk), .rst_o(rst));

	vdma_top u_dut (
		.s_wb_clk_i (clk), .s_wb_rst_i (rst),
		.s_wb_adr_i (wb_adr), .s_wb_dat_i (wb_dat_w), .s_wb_we_i (wb_we),
		.s_wb_sel_i (wb_sel), .s_wb_stb_i (wb_stb),
		.s_wb_dat_o (wb_dat_r), .s_wb_ack_o (wb_ack),
		.m_axi4_arid_o (arid), .m_axi4_araddr_o (araddr), .m_axi4_arburst_o (arburst),
		.m_axi4_arlen_o (arlen), .m_axi4_arsize_o (arsize),
		.m_axi4_arvalid_o (arvalid), .m_axi4_arready_i (arready),
		.m_axi4_rdata_i (rdata), .m_axi4_rvalid_i (rvalid), .m_axi4_rready_o (rready),
		.m_axi4s_tdata_o (tdata), .m_axi4s_tuser_o (tuser), .m_axi4s_tlast_o (tlast),
		.m_axi4s_tvalid_o (tvalid), .m_axi4s_tready_i (tready)
	);

	// galois form, one step per bit
	function automatic bit lfsr_bit();
		bit b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return b;
	endfunction

	task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timeout while waiting for %s", what);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic wb_write(input logic [7:0] adr, input logic [31:0] dat);
		@(posedge clk);
		#10;
		wb_adr = adr;
		wb_dat_w = dat;
		wb_we = 1'b1;
		wb_stb = 1'b1;
		#40;
		check_val(32'(wb_ack), 32'd1, "wishbone ack on write");
		@(posedge clk);
		#10;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// read data is combinational, sampled mid cycle
	task automatic wb_read(input logic [7:0] adr, output logic [31:0] dat);
		@(posedge clk);
		#10;
		wb_adr = adr;
		wb_we = 1'b0;
		wb_stb = 1'b1;
		#40;
		dat = wb_dat_r;
		check_val(32'(wb_ack), 32'd1, "wishbone ack on read");
		@(posedge clk);
		#10;
		wb_stb = 1'b0;
	endtask

	// ----------------------------------------
	// memory model and stream sink
	// ----------------------------------------
	always @(posedge clk) begin
		int col;
		if (arvalid && arready) begin
			ar_addr_q.push_back(araddr);
			ar_len_q.push_back(int'(arlen));
			ar_cnt++;
			col = int'((araddr - exp_addr) % exp_stride) / 4;
			check_val(32'(arid), 32'd0, "arid");
			check_val(32'(arburst), 32'd1, "arburst incr");
			check_val(32'(arsize), 32'd2, "arsize 4 bytes");
			check_val(32'(arlen <= exp_arlen), 32'd1, "burst length above arlen");
			check_val(32'(col + int'(arlen) + 1 <= exp_w), 32'd1, "burst crosses line");
		end
	end

	// R beats, AR ready and stream ready in one process
	initial begin
		bit hs;
		bit rmode;
		forever begin
			@(posedge clk);
			hs = rvalid && rready;
			rmode = ready_mode;
			#10;
			if (hs) begin
				cur_addr = cur_addr + 4;
				beats_left--;
			end
			if (beats_left == 0 && ar_addr_q.size() > 0) begin
				cur_addr = ar_addr_q.pop_front();
				beats_left = ar_len_q.pop_front() + 1;
			end
			if (!(rvalid && !hs)) begin
				rvalid = (beats_left > 0) ? (lfsr_bit() | lfsr_bit()) : 1'b0;
			end
			rdata = cur_addr;
			arready = lfsr_bit();
			tready = rmode ? lfsr_bit() : 1'b1;
		end
	end

	always @(posedge clk) begin
		int x;
		int y;
		logic [31:0] a;
		if (tvalid && tready) begin
			x = pix_cnt % exp_w;
			y = pix_cnt / exp_w;
			a = exp_addr + 32'(y * exp_stride) + 32'(4 * x);
			check_val(32'(pix_cnt < exp_w * exp_h), 32'd1, "extra pixel");
			check_val(32'(tdata), {8'h00, a[23:0]}, "pixel data");
			check_val(32'(tuser), 32'(pix_cnt == 0), "tuser");
			check_val(32'(tlast), 32'(x == exp_w - 1), "tlast");
			pix_cnt++;
		end
	end

	task automatic write_params(input int w, input int h, input int s, input logic [31:0] a,
	                            input int l);
		wb_write(vdma_pkg::REG_PARAM_ADDR, a);
		wb_write(vdma_pkg::REG_PARAM_STRIDE, 32'(s));
		wb_write(vdma_pkg::REG_PARAM_WIDTH, 32'(w));
		wb_write(vdma_pkg::REG_PARAM_HEIGHT, 32'(h));
		wb_write(vdma_pkg::REG_PARAM_ARLEN, 32'(l));
	endtask

	// one frame, then enable is cleared so the frame stops cleanly
	task automatic run_frame(input bit upd);
		logic [31:0] v;
		logic [31:0] idx0;
		int n;
		int ar_seen;
		pix_cnt = 0;
		ar_cnt = 0;
		wb_read(vdma_pkg::REG_CTL_INDEX, idx0);
		wb_write(vdma_pkg::REG_CTL_CONTROL, {30'd0, upd, 1'b1});
		n = 0;
		v = idx0;
		while (v == idx0) begin
			if (n > 200) abort_run("frame index to change");
			n++;
			wb_read(vdma_pkg::REG_CTL_INDEX, v);
		end
		check_val(v, (idx0 + 1) & 32'hff, "index step");
		wb_read(vdma_pkg::REG_CTL_CONTROL, v);
		check_val(v, 32'd1, "update bit after frame start");
		wb_write(vdma_pkg::REG_CTL_CONTROL, 32'd0);
		n = 0;
		v = 1;
		while (v != 0) begin
			if (n > 2000) abort_run("status to go idle");
			n++;
			wb_read(vdma_pkg::REG_CTL_STATUS, v);
		end
		n = 0;
		while (pix_cnt < exp_w * exp_h) begin
			if (n > 5000) abort_run("all pixels on the stream");
			n++;
			@(posedge clk);
		end
		check_val(32'(ar_cnt), 32'(exp_bursts), "burst count");
		wb_read(vdma_pkg::REG_MONITOR_ADDR, v);
		check_val(v, exp_addr, "monitor addr");
		wb_read(vdma_pkg::REG_MONITOR_STRIDE, v);
		check_val(v, 32'(exp_stride), "monitor stride");
		wb_read(vdma_pkg::REG_MONITOR_WIDTH, v);
		check_val(v, 32'(exp_w), "monitor width");
		wb_read(vdma_pkg::REG_MONITOR_HEIGHT, v);
		check_val(v, 32'(exp_h), "monitor height");
		wb_read(vdma_pkg::REG_MONITOR_ARLEN, v);
		check_val(v, 32'(exp_arlen), "monitor arlen");
		ar_seen = ar_cnt;
		repeat (40) @(posedge clk);
		check_val(32'(ar_cnt), 32'(ar_seen), "AR after stop");
	endtask

	initial begin
		int fd;
		int id;
		int mode;
		int e0;
		string line;
		logic [31:0] v;
		wb_adr = '0;
		wb_dat_w = '0;
		wb_we = 1'b0;
		wb_sel = 4'hf;
		wb_stb = 1'b0;
		arready = 1'b1;
		rvalid = 1'b0;
		rdata = '0;
		tready = 1'b1;
		beats_left = 0;
		cur_addr = '0;
		exp_w = 1;
		exp_h = 1;
		exp_stride = 4;
		exp_arlen = 0;
		exp_addr = '0;
		while (rst !== 1'b0) @(posedge clk);

		e0 = errors;
		wb_read(vdma_pkg::REG_ID, v);
		check_val(v, `VDMA_CORE_ID, "id");
		wb_read(vdma_pkg::REG_PARAM_WIDTH, v);
		check_val(v, 32'd640, "reset width");
		wb_read(vdma_pkg::REG_CTL_CONTROL, v);
		check_val(v, 32'd0, "reset control");
		wb_write(vdma_pkg::REG_PARAM_ADDR, 32'h1234_5677);
		wb_read(vdma_pkg::REG_PARAM_ADDR, v);
		check_val(v, 32'h1234_5674, "addr alignment");
		wb_write(vdma_pkg::REG_PARAM_STRIDE, 32'h0000_0103);
		wb_read(vdma_pkg::REG_PARAM_STRIDE, v);
		check_val(v, 32'h0000_0100, "stride alignment");
		wb_read(8'h3f, v);
		check_val(v, 32'd0, "unknown offset");
		tests++;
		$display("test registers: %0d errors", errors - e0);

		fd = $fopen("dv/vdma_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open dv/vdma_testdata.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line[0] == "#") continue;
				if ($sscanf(line, "%d %d %d %d %h %d %d %d", id, exp_w, exp_h, exp_stride,
				            exp_addr, exp_arlen, mode, exp_bursts) != 8) continue;
				e0 = errors;
				ready_mode = (mode != 0);
				write_params(exp_w, exp_h, exp_stride, exp_addr, exp_arlen);
				run_frame(1'b1);
				tests++;
				$display("test %0d frame %0dx%0d: %0d errors", id, exp_w, exp_h, errors - e0);
			end
			$fclose(fd);

			// new values without update must not reach the next frame
			e0 = errors;
			write_params(3, 1, 16, 32'h0000_9000, 1);
			run_frame(1'b0);
			tests++;
			$display("test hold parameters: %0d errors", errors - e0);
		end

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// ==== dv/vdma_testdata.txt ====
# id width height stride addr(hex) arlen ready_mode(0 always, 1 lfsr) bursts
# bursts = ceil(width / (arlen + 1)) * height
1 8 4 64 00001000 3 0 8
2 10 3 48 00002004 3 1 9
3 12 2 64 00003000 15 1 2
4 16 2 128 00040000 0 0 32
5 20 3 96 00050010 7 1 9

// ==== project.f ====
+incdir+verilog
verilog/vdma_pkg.sv
verilog/vdma_regs.sv
verilog/vdma_ar_gen.sv
verilog/vdma_beat_tracker.sv
verilog/vdma_stream_out.sv
verilog/vdma_top.sv
dv/tb_clkgen.sv
dv/tb_vdma_asserts.sv
dv/tb_vdma.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_vdma -o tb_vdma
./obj_dir/tb_vdma > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test OK$" sim.log; then
	exit 0
fi
exit 1
